//--- src/l2_write_defines.svh
`ifndef L2_WRITE_DEFINES_SVH
`define L2_WRITE_DEFINES_SVH

// byte address and memory beat widths
`define L2W_ADDR_W 32
`define L2W_DATA_W 32

// log2 of words per line
`define L2W_OFFSET_W 2
`define L2W_LINE_WORDS (1 << `L2W_OFFSET_W)
`define L2W_LINE_W (`L2W_LINE_WORDS * `L2W_DATA_W)

// burst encoding for full 32-bit beats
`define L2W_BURST_SIZE 3'd2
`define L2W_LEN_W 8
`define L2W_SIZE_W 3
`define L2W_STRB_W (`L2W_DATA_W / 8)

`endif

//--- src/l2_write_pkg.sv
package l2_write_pkg;

    // write path states shared by controller, arbiter and top
    typedef enum logic [4:0] {
        IDLE   = 5'd0,
        DMA_AW = 5'd1,
        DMA_W  = 5'd2,
        DMA_R  = 5'd3,
        WRT_W  = 5'd4
    } wr_state_e;

    // eviction buffer phases
    typedef enum logic [1:0] {
        BUF_EMPTY = 2'd0,
        BUF_ADDR  = 2'd1,
        BUF_DATA  = 2'd2,
        BUF_RESP  = 2'd3
    } buf_phase_e;

endpackage

//--- src/write_ctrl.sv
module write_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    dma_req,
    input  logic                    busy,
    input  logic                    waddr_ok,
    input  logic                    wready,
    input  logic                    bvalid,
    output l2_write_pkg::wr_state_e state
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= l2_write_pkg::IDLE;
        end else begin
            case (state)
                l2_write_pkg::IDLE: begin
                    // a running burst goes first to keep memory order
                    if (busy) begin
                        state <= l2_write_pkg::WRT_W;
                    end else if (dma_req) begin
                        state <= l2_write_pkg::DMA_AW;
                    end
                end
                l2_write_pkg::WRT_W: begin
                    if (!busy) begin
                        state <= l2_write_pkg::IDLE;
                    end
                end
                l2_write_pkg::DMA_AW: begin
                    if (waddr_ok) begin
                        state <= l2_write_pkg::DMA_W;
                    end
                end
                l2_write_pkg::DMA_W: begin
                    if (wready) begin
                        state <= l2_write_pkg::DMA_R;
                    end
                end
                l2_write_pkg::DMA_R: begin
                    // buffer may be loaded meanwhile and drains from IDLE
                    if (bvalid) begin
                        state <= l2_write_pkg::IDLE;
                    end
                end
                default: begin
                    state <= l2_write_pkg::IDLE;
                end
            endcase
        end
    end

    // response wait is only left on bvalid
    a_dma_r_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (state == l2_write_pkg::DMA_R && !bvalid) |=> (state == l2_write_pkg::DMA_R)
    );

endmodule

//--- src/write_buffer.sv
`include "l2_write_defines.svh"

module write_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   line_req,
    input  logic [`L2W_ADDR_W-1:0] line_addr,
    input  logic [`L2W_LINE_W-1:0] line_data,
    input  logic                   buf_waddr_ok,
    input  logic                   buf_wready,
    input  logic                   buf_bvalid,
    output logic                   line_ok,
    output logic                   busy,
    output logic [`L2W_ADDR_W-1:0] buf_waddr,
    output logic [`L2W_DATA_W-1:0] buf_wdata,
    output logic                   buf_wvalid,
    output logic                   buf_wwvalid,
    output logic                   buf_wlast,
    output logic                   buf_bready
);

    // byte offset bits within one line
    localparam int ALIGN_W = `L2W_OFFSET_W + $clog2(`L2W_DATA_W / 8);
    localparam logic [`L2W_ADDR_W-1:0] OFFSET_MASK = (1 << ALIGN_W) - 1;
    localparam logic [`L2W_OFFSET_W-1:0] LAST_BEAT = '1;

    l2_write_pkg::buf_phase_e phase;
    logic [`L2W_OFFSET_W-1:0] beat;
    logic [`L2W_ADDR_W-1:0]   addr_q;
    logic [`L2W_LINE_W-1:0]   line_q;

    // accept only when empty and release the cache in the same cycle
    assign line_ok = line_req && (phase == l2_write_pkg::BUF_EMPTY);
    assign busy    = (phase != l2_write_pkg::BUF_EMPTY);

    assign buf_waddr   = addr_q;
    assign buf_wdata   = line_q[beat * `L2W_DATA_W +: `L2W_DATA_W];
    assign buf_wvalid  = (phase == l2_write_pkg::BUF_ADDR);
    assign buf_wwvalid = (phase == l2_write_pkg::BUF_DATA);
    assign buf_wlast   = (phase == l2_write_pkg::BUF_DATA) && (beat == LAST_BEAT);
    assign buf_bready  = (phase == l2_write_pkg::BUF_RESP);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase <= l2_write_pkg::BUF_EMPTY;
            beat  <= '0;
        end else begin
            case (phase)
                l2_write_pkg::BUF_EMPTY: begin
                    if (line_req) begin
                        phase <= l2_write_pkg::BUF_ADDR;
                        beat  <= '0;
                    end
                end
                l2_write_pkg::BUF_ADDR: begin
                    if (buf_waddr_ok) begin
                        phase <= l2_write_pkg::BUF_DATA;
                    end
                end
                l2_write_pkg::BUF_DATA: begin
                    // lowest word first and the counter wraps back to zero
                    if (buf_wready) begin
                        beat <= beat + 1'b1;
                        if (beat == LAST_BEAT) begin
                            phase <= l2_write_pkg::BUF_RESP;
                        end
                    end
                end
                l2_write_pkg::BUF_RESP: begin
                    if (buf_bvalid) begin
                        phase <= l2_write_pkg::BUF_EMPTY;
                    end
                end
                default: begin
                    phase <= l2_write_pkg::BUF_EMPTY;
                end
            endcase
        end
    end

    // line payload aligned to the line boundary
    always_ff @(posedge clk) begin
        if (line_ok) begin
            addr_q <= line_addr & ~OFFSET_MASK;
            line_q <= line_data;
        end
    end

    // first beat of a burst carries wlast only for one-word lines
    a_wlast_final: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(buf_wwvalid) |-> (buf_wlast == (`L2W_LINE_WORDS == 1))
    );

    // beat and its payload held until the slave takes it
    a_wwvalid_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (buf_wwvalid && !buf_wready) |=>
            (buf_wwvalid && $stable(buf_wdata) && $stable(buf_wlast))
    );

    // the accepted last beat hands over to the response phase
    a_last_to_resp: assert property (
        @(posedge clk) disable iff (!rstn)
        (buf_wwvalid && buf_wready && buf_wlast) |=> (buf_bready && !buf_wwvalid)
    );

endmodule

//--- src/write_arbiter.sv
`include "l2_write_defines.svh"

module write_arbiter (
    input  logic                    clk,
    input  logic                    rstn,
    input  l2_write_pkg::wr_state_e state,
    // cache request
    input  logic                    req,
    input  logic [`L2W_ADDR_W-1:0]  addr,
    input  logic [`L2W_LINE_W-1:0]  line,
    input  logic [`L2W_SIZE_W-1:0]  size,
    input  logic [`L2W_STRB_W-1:0]  wstrb,
    input  logic                    dma_sign,
    // buffer side
    input  logic [`L2W_ADDR_W-1:0]  buf_waddr,
    input  logic [`L2W_DATA_W-1:0]  buf_wdata,
    input  logic                    buf_wvalid,
    input  logic                    buf_wwvalid,
    input  logic                    buf_wlast,
    input  logic                    buf_bready,
    input  logic                    line_ok,
    // memory ready and response
    input  logic                    waddr_ok,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    dma_req,
    output logic                    line_req,
    output logic [`L2W_ADDR_W-1:0]  line_addr,
    output logic [`L2W_LINE_W-1:0]  line_data,
    output logic                    addr_ok,
    output logic                    buf_waddr_ok,
    output logic                    buf_wready,
    output logic                    buf_bvalid,
    output logic [`L2W_ADDR_W-1:0]  waddr,
    output logic [`L2W_DATA_W-1:0]  wdata,
    output logic                    wvalid,
    output logic                    wwvalid,
    output logic                    wlast,
    output logic                    bready,
    output logic [`L2W_LEN_W-1:0]   len,
    output logic [`L2W_SIZE_W-1:0]  wsize,
    output logic [`L2W_STRB_W-1:0]  mem_wstrb
);

    localparam int BURST_LEN = `L2W_LINE_WORDS - 1;

    // direct write captured during its address phase
    logic [`L2W_STRB_W-1:0] dma_strb_q;
    logic [`L2W_ADDR_W-1:0] dma_addr_q;
    logic [`L2W_DATA_W-1:0] dma_data_q;

    assign dma_req   = req && dma_sign;
    assign line_addr = addr;
    assign line_data = line;

    always_comb begin
        line_req     = 1'b0;
        addr_ok      = 1'b0;
        buf_waddr_ok = 1'b0;
        buf_wready   = 1'b0;
        buf_bvalid   = 1'b0;
        waddr        = '0;
        wdata        = '0;
        wvalid       = 1'b0;
        wwvalid      = 1'b0;
        wlast        = 1'b0;
        bready       = 1'b0;
        len          = '0;
        wsize        = '0;
        mem_wstrb    = '0;
        case (state)
            l2_write_pkg::IDLE, l2_write_pkg::WRT_W: begin
                // buffer owns all three channels
                line_req     = req && !dma_sign;
                addr_ok      = line_ok;
                len          = BURST_LEN[`L2W_LEN_W-1:0];
                wsize        = `L2W_BURST_SIZE;
                mem_wstrb    = '1;
                waddr        = buf_waddr;
                wdata        = buf_wdata;
                wvalid       = buf_wvalid;
                wwvalid      = buf_wwvalid;
                wlast        = buf_wlast;
                bready       = buf_bready;
                buf_waddr_ok = waddr_ok;
                buf_wready   = wready;
                buf_bvalid   = bvalid;
            end
            l2_write_pkg::DMA_AW: begin
                waddr     = addr;
                wvalid    = 1'b1;
                wsize     = size;
                mem_wstrb = wstrb;
            end
            l2_write_pkg::DMA_W: begin
                // cache released together with the data beat
                addr_ok   = dma_req && wready;
                waddr     = dma_addr_q;
                wdata     = dma_data_q;
                wwvalid   = 1'b1;
                wlast     = 1'b1;
                wsize     = size;
                mem_wstrb = dma_strb_q;
            end
            l2_write_pkg::DMA_R: begin
                // an eviction may be taken while the response is pending
                line_req  = req && !dma_sign;
                addr_ok   = line_ok;
                waddr     = dma_addr_q;
                wdata     = dma_data_q;
                bready    = 1'b1;
                mem_wstrb = dma_strb_q;
            end
            default: begin
                line_req = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == l2_write_pkg::DMA_AW) begin
            dma_strb_q <= wstrb;
            dma_addr_q <= addr;
            dma_data_q <= line[`L2W_DATA_W-1:0];
        end
    end

    // address valid from either source held until memory takes it
    a_wvalid_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (wvalid && !waddr_ok) |=> wvalid
    );

endmodule

//--- src/l2_write_top.sv
`include "l2_write_defines.svh"

module l2_write_top (
    input  logic                   clk,
    input  logic                   rstn,
    // cache side
    input  logic                   req,
    input  logic [`L2W_ADDR_W-1:0] addr,
    input  logic [`L2W_LINE_W-1:0] line,
    input  logic [`L2W_SIZE_W-1:0] size,
    input  logic [`L2W_STRB_W-1:0] wstrb,
    input  logic                   dma_sign,
    output logic                   addr_ok,
    // memory address channel
    output logic [`L2W_ADDR_W-1:0] waddr,
    output logic                   wvalid,
    output logic [`L2W_LEN_W-1:0]  len,
    output logic [`L2W_SIZE_W-1:0] wsize,
    output logic [`L2W_STRB_W-1:0] mem_wstrb,
    input  logic                   waddr_ok,
    // memory data channel
    output logic [`L2W_DATA_W-1:0] wdata,
    output logic                   wwvalid,
    output logic                   wlast,
    input  logic                   wready,
    // memory response channel
    input  logic                   bvalid,
    output logic                   bready
);

    l2_write_pkg::wr_state_e state;

    logic                   dma_req;
    logic                   line_req;
    logic                   line_ok;
    logic                   busy;
    logic [`L2W_ADDR_W-1:0] line_addr;
    logic [`L2W_LINE_W-1:0] line_data;
    logic [`L2W_ADDR_W-1:0] buf_waddr;
    logic [`L2W_DATA_W-1:0] buf_wdata;
    logic                   buf_wvalid;
    logic                   buf_wwvalid;
    logic                   buf_wlast;
    logic                   buf_bready;
    logic                   buf_waddr_ok;
    logic                   buf_wready;
    logic                   buf_bvalid;

    write_ctrl u_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .dma_req  (dma_req),
        .busy     (busy),
        .waddr_ok (waddr_ok),
        .wready   (wready),
        .bvalid   (bvalid),
        .state    (state)
    );

    write_arbiter u_arb (
        .clk          (clk),
        .rstn         (rstn),
        .state        (state),
        .req          (req),
        .addr         (addr),
        .line         (line),
        .size         (size),
        .wstrb        (wstrb),
        .dma_sign     (dma_sign),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata),
        .buf_wvalid   (buf_wvalid),
        .buf_wwvalid  (buf_wwvalid),
        .buf_wlast    (buf_wlast),
        .buf_bready   (buf_bready),
        .line_ok      (line_ok),
        .waddr_ok     (waddr_ok),
        .wready       (wready),
        .bvalid       (bvalid),
        .dma_req      (dma_req),
        .line_req     (line_req),
        .line_addr    (line_addr),
        .line_data    (line_data),
        .addr_ok      (addr_ok),
        .buf_waddr_ok (buf_waddr_ok),
        .buf_wready   (buf_wready),
        .buf_bvalid   (buf_bvalid),
        .waddr        (waddr),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .wwvalid      (wwvalid),
        .wlast        (wlast),
        .bready       (bready),
        .len          (len),
        .wsize        (wsize),
        .mem_wstrb    (mem_wstrb)
    );

    write_buffer u_buf (
        .clk          (clk),
        .rstn         (rstn),
        .line_req     (line_req),
        .line_addr    (line_addr),
        .line_data    (line_data),
        .buf_waddr_ok (buf_waddr_ok),
        .buf_wready   (buf_wready),
        .buf_bvalid   (buf_bvalid),
        .line_ok      (line_ok),
        .busy         (busy),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata),
        .buf_wvalid   (buf_wvalid),
        .buf_wwvalid  (buf_wwvalid),
        .buf_wlast    (buf_wlast),
        .buf_bready   (buf_bready)
    );

endmodule

//--- dv/tb_l2_write.sv
`include "l2_write_defines.svh"

module tb_l2_write;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ    = 200;
    localparam int WORDS      = `L2W_LINE_WORDS;
    localparam int LINE_BYTES = WORDS * 4;

    logic                   clk;
    logic                   rstn;
    logic                   req;
    logic [`L2W_ADDR_W-1:0] addr;
    logic [`L2W_LINE_W-1:0] line;
    logic [`L2W_SIZE_W-1:0] size;
    logic [`L2W_STRB_W-1:0] wstrb;
    logic                   dma_sign;
    logic                   addr_ok;
    logic [`L2W_ADDR_W-1:0] waddr;
    logic                   wvalid;
    logic [`L2W_LEN_W-1:0]  len;
    logic [`L2W_SIZE_W-1:0] wsize;
    logic [`L2W_STRB_W-1:0] mem_wstrb;
    logic                   waddr_ok;
    logic [`L2W_DATA_W-1:0] wdata;
    logic                   wwvalid;
    logic                   wlast;
    logic                   wready;
    logic                   bvalid;
    logic                   bready;

    integer seed = 32'h1a0c;

    // requests in issue order popped at each address phase
    logic [`L2W_ADDR_W-1:0] exp_addr_q[$];
    logic                   exp_dma_q[$];
    logic [`L2W_SIZE_W-1:0] exp_size_q[$];
    logic [`L2W_STRB_W-1:0] exp_strb_q[$];
    logic [`L2W_LINE_W-1:0] exp_line_q[$];

    logic [7:0] slave_mem[int unsigned];
    logic [7:0] ref_mem[int unsigned];

    // slave state for the transaction on the bus
    logic [`L2W_ADDR_W-1:0] cur_addr;
    logic [`L2W_STRB_W-1:0] cur_strb;
    logic [`L2W_LINE_W-1:0] cur_line;
    logic                   cur_dma;
    int                     cur_len;
    int                     beat_idx;
    logic                   in_data;
    logic                   resp_pend;
    int                     resp_count;
    int                     aw_cnt;
    int                     w_cnt;
    int                     b_cnt;
    logic                   next_waddr_ok;
    logic                   next_wready;
    logic                   next_bvalid;

    // values seen while a valid waited
    logic                   aw_waiting;
    logic                   w_waiting;
    logic [`L2W_ADDR_W-1:0] held_waddr;
    logic [`L2W_LEN_W-1:0]  held_len;
    logic [`L2W_DATA_W-1:0] held_wdata;
    logic                   held_wlast;

    l2_write_top dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .addr      (addr),
        .line      (line),
        .size      (size),
        .wstrb     (wstrb),
        .dma_sign  (dma_sign),
        .addr_ok   (addr_ok),
        .waddr     (waddr),
        .wvalid    (wvalid),
        .len       (len),
        .wsize     (wsize),
        .mem_wstrb (mem_wstrb),
        .waddr_ok  (waddr_ok),
        .wdata     (wdata),
        .wwvalid   (wwvalid),
        .wlast     (wlast),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // reference memory updated when the cache sees addr_ok
    task automatic update_reference(input logic [31:0] a, input logic dma,
                                    input logic [3:0] strb, input logic [`L2W_LINE_W-1:0] data);
        logic [31:0] base;
        if (dma) begin
            base = {a[31:2], 2'b00};
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ref_mem[base + b] = data[8*b +: 8];
            end
        end else begin
            base = a & ~(LINE_BYTES - 1);
            for (int b = 0; b < LINE_BYTES; b++) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
    endtask

    function automatic int rand_delay();
        logic [31:0] rnd;
        rnd = $random(seed);
        return int'(rnd[1:0]);
    endfunction

    // memory slave decides at the falling edge and drives readies after the rising edge
    always @(negedge clk) begin
        if (!rstn) begin
            next_waddr_ok = 1'b0;
            next_wready   = 1'b0;
            next_bvalid   = 1'b0;
            aw_waiting    = 1'b0;
            w_waiting     = 1'b0;
        end else begin
            if (aw_waiting) begin
                check_value("aw valid hold", 1, wvalid);
                check_value("aw addr hold", held_waddr, waddr);
                check_value("aw len hold", held_len, len);
            end
            if (w_waiting) begin
                check_value("w valid hold", 1, wwvalid);
                check_value("w data hold", held_wdata, wdata);
                check_value("w last hold", held_wlast, wlast);
            end
            aw_waiting = wvalid && !waddr_ok;
            w_waiting  = wwvalid && !wready;
            held_waddr = waddr;
            held_len   = len;
            held_wdata = wdata;
            held_wlast = wlast;

            if (wvalid && waddr_ok) begin
                if (exp_addr_q.size() == 0) begin
                    $display("address phase seen with no request outstanding");
                    fail_run();
                end
                cur_addr = exp_addr_q.pop_front();
                cur_dma  = exp_dma_q.pop_front();
                cur_line = exp_line_q.pop_front();
                cur_strb = exp_strb_q.pop_front();
                if (cur_dma) begin
                    check_value("dma len", 0, len);
                    check_value("dma size", exp_size_q.pop_front(), wsize);
                    check_value("dma strobe", cur_strb, mem_wstrb);
                    check_value("dma addr", cur_addr, waddr);
                end else begin
                    void'(exp_size_q.pop_front());
                    cur_strb = '1;
                    cur_addr = cur_addr & ~(LINE_BYTES - 1);
                    check_value("line len", WORDS - 1, len);
                    check_value("line size", 2, wsize);
                    check_value("line strobe", 4'hf, mem_wstrb);
                    check_value("line addr", cur_addr, waddr);
                end
                cur_len  = cur_dma ? 0 : WORDS - 1;
                beat_idx = 0;
                in_data  = 1'b1;
            end

            if (wwvalid && wready) begin
                check_value("beat after address", 1, in_data);
                check_value("beat count", 1, beat_idx <= cur_len);
                check_value("beat wlast", beat_idx == cur_len, wlast);
                check_value("beat data", cur_line[32*beat_idx +: 32], wdata);
                for (int b = 0; b < 4; b++) begin
                    if (cur_strb[b]) slave_mem[cur_addr + 4*beat_idx + b] = wdata[8*b +: 8];
                end
                beat_idx++;
                if (wlast) begin
                    in_data   = 1'b0;
                    resp_pend = 1'b1;
                end
            end

            if (bvalid && bready) begin
                resp_count++;
                next_bvalid = 1'b0;
                b_cnt       = rand_delay();
            end else if (resp_pend && !bvalid) begin
                if (b_cnt == 0) begin
                    next_bvalid = 1'b1;
                    resp_pend   = 1'b0;
                end else begin
                    b_cnt--;
                end
            end

            // a zero delay keeps ready high for the next valid
            if (wvalid && waddr_ok) begin
                aw_cnt        = rand_delay();
                next_waddr_ok = (aw_cnt == 0);
            end else if (wvalid && !next_waddr_ok) begin
                if (aw_cnt > 1) begin
                    aw_cnt--;
                end else begin
                    next_waddr_ok = 1'b1;
                end
            end
            if (wwvalid && wready) begin
                w_cnt       = rand_delay();
                next_wready = (w_cnt == 0);
            end else if (wwvalid && !next_wready) begin
                if (w_cnt > 1) begin
                    w_cnt--;
                end else begin
                    next_wready = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        waddr_ok <= next_waddr_ok;
        wready   <= next_wready;
        bvalid   <= next_bvalid;
    end

    initial begin
        #(NUM_REQ * 40 * 10);
        $display("timeout: requests did not drain within the time limit");
        fail_run();
    end

    initial begin
        logic [31:0] rnd;
        req           = 1'b0;
        addr          = '0;
        line          = '0;
        size          = '0;
        wstrb         = '0;
        dma_sign      = 1'b0;
        waddr_ok      = 1'b0;
        wready        = 1'b0;
        bvalid        = 1'b0;
        rstn          = 1'b0;
        next_waddr_ok = 1'b0;
        next_wready   = 1'b0;
        next_bvalid   = 1'b0;
        resp_pend     = 1'b0;
        resp_count    = 0;
        in_data       = 1'b0;
        aw_cnt        = 0;
        w_cnt         = 0;
        b_cnt         = 0;
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        @(negedge clk);
        check_value("reset wvalid", 0, wvalid);
        check_value("reset wwvalid", 0, wwvalid);
        check_value("reset wlast", 0, wlast);
        check_value("reset bready", 0, bready);
        check_value("reset addr_ok", 0, addr_ok);

        for (int i = 0; i < NUM_REQ; i++) begin
            @(posedge clk);
            #1;
            rnd      = $random(seed);
            dma_sign = rnd[0];
            wstrb    = rnd[7:4];
            size     = (rnd[9:8] == 2'd3) ? 3'd2 : {1'b0, rnd[9:8]};
            addr     = 32'h1000 + {24'd0, rnd[23:18], 2'b00};
            for (int w = 0; w < WORDS; w++) begin
                line[32*w +: 32] = $random(seed);
            end
            req = 1'b1;
            exp_addr_q.push_back(addr);
            exp_dma_q.push_back(dma_sign);
            exp_size_q.push_back(size);
            exp_strb_q.push_back(wstrb);
            exp_line_q.push_back(line);
            do @(negedge clk); while (!addr_ok);
            update_reference(addr, dma_sign, wstrb, line);
            @(posedge clk);
            #1 req = 1'b0;
            repeat (rand_delay()) @(posedge clk);
        end

        while (resp_count < NUM_REQ) @(negedge clk);
        foreach (ref_mem[a]) begin
            if (!slave_mem.exists(a)) begin
                $display("byte at %h was never written to memory", a);
                fail_run();
            end
            check_value("final memory", ref_mem[a], slave_mem[a]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb.f
+incdir+src
src/l2_write_pkg.sv
src/write_ctrl.sv
src/write_buffer.sv
src/write_arbiter.sv
src/l2_write_top.sv
dv/tb_l2_write.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_l2_write
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build outputs"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJDIR)
